// ==== design/video_cfg.svh ====
// video configuration macros for the scaled raster geometry, word address width and buffer depth
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// horizontal geometry in pixel clocks
`define VID_H_TOTAL     64
`define VID_H_PIX_BEG   16
`define VID_H_PIX       32
`define VID_H_SYNC_BEG  52
`define VID_H_SYNC_LEN  6

// vertical geometry in lines
`define VID_V_TOTAL     24
`define VID_V_PIX_BEG   4
`define VID_V_PIX       16
`define VID_V_SYNC_BEG  21
`define VID_V_SYNC_LEN  2

// DRAM word address
`define VID_ADDR_W      15

// sized for 4-bit colour mode as the wider of the two
`define VID_LINE_WORDS  8

`endif

// ==== design/video_pkg.sv ====
// video package holding the screen modes, the colour word and the two views of a fetched word
`default_nettype none

package video_pkg;

	// vconfig bit 0
	typedef enum logic {
		MODE_ZX   = 1'b0,
		MODE_4BPP = 1'b1
	} scr_mode_e;

	// g/r/b order follows the zx attribute bits
	typedef struct packed {
		logic bright;
		logic green;
		logic red;
		logic blue;
	} colour_t;

	typedef union packed {
		struct packed {
			logic       flash;
			logic       bright;
			logic [2:0] paper;
			logic [2:0] ink;
			logic [7:0] bitmap;
		} zx;
		// c4[3] is the leftmost pixel
		colour_t [3:0] c4;
	} vword_u;

endpackage

`default_nettype wire

// ==== design/video_sync.sv ====
// video sync block generating raster counters, raw syncs, active window and line/frame events
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_sync (
	input  wire        clk,
	input  wire        rst_n,
	output logic [5:0] hcnt,
	output logic [4:0] vcnt,
	output logic       line_start,
	output logic       frame_start,
	output logic       int_start,
	output logic       hsync_raw,
	output logic       vsync_raw,
	output logic       pix_active
);

	logic [5:0] h_next;
	logic [4:0] v_next;
	logic       h_wrap;
	logic       h_sync_win;
	logic       v_sync_win;
	logic       h_pix_win;
	logic       v_pix_win;

	assign h_wrap = (hcnt == 6'(`VID_H_TOTAL - 1));
	assign h_next = h_wrap ? 6'd0 : hcnt + 6'd1;

	always_comb begin
		v_next = vcnt;
		if (h_wrap) begin
			if (vcnt == 5'(`VID_V_TOTAL - 1))
				v_next = 5'd0;
			else
				v_next = vcnt + 5'd1;
		end
	end

	// windows decoded on the next count so the registered flags line up with hcnt/vcnt
	assign h_sync_win = (h_next >= 6'(`VID_H_SYNC_BEG)) &&
		(h_next < 6'(`VID_H_SYNC_BEG + `VID_H_SYNC_LEN));
	assign v_sync_win = (v_next >= 5'(`VID_V_SYNC_BEG)) &&
		(v_next < 5'(`VID_V_SYNC_BEG + `VID_V_SYNC_LEN));
	assign h_pix_win = (h_next >= 6'(`VID_H_PIX_BEG)) &&
		(h_next < 6'(`VID_H_PIX_BEG + `VID_H_PIX));
	assign v_pix_win = (v_next >= 5'(`VID_V_PIX_BEG)) &&
		(v_next < 5'(`VID_V_PIX_BEG + `VID_V_PIX));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt        <= '0;
			vcnt        <= '0;
			line_start  <= 1'b0;
			frame_start <= 1'b0;
			hsync_raw   <= 1'b1;
			vsync_raw   <= 1'b1;
			pix_active  <= 1'b0;
		end else begin
			hcnt        <= h_next;
			vcnt        <= v_next;
			line_start  <= (h_next == 6'd0);
			frame_start <= (h_next == 6'd0) && (v_next == 5'd0);
			hsync_raw   <= !h_sync_win;
			vsync_raw   <= !v_sync_win;
			pix_active  <= h_pix_win && v_pix_win;
		end
	end

	// frame interrupt to the cpu side
	assign int_start = frame_start;

endmodule

`default_nettype wire

// ==== design/video_fetch.sv ====
// video fetch FSM reading one screen row per line from DRAM into the line buffer
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_fetch (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    line_start,
	input  wire [4:0]              vcnt,
	input  wire [7:0]              vconfig,
	input  wire [7:0]              scr_page,
	output logic                   video_go,
	output logic [`VID_ADDR_W-1:0] video_addr,
	input  wire                    video_next,
	input  wire                    video_strobe,
	input  wire [15:0]             video_data,
	output logic                   buf_we,
	output logic [2:0]             buf_waddr,
	output logic [15:0]            buf_wdata
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_REQ  = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;

	logic [1:0]           state;
	logic [3:0]           row_q;
	logic [6:0]           page_q;
	logic [2:0]           widx;
	video_pkg::scr_mode_e mode_q;
	logic [5:0]           row_calc;
	logic                 row_vis;
	logic                 last_word;

	// line v prefetches row v+1-VID_V_PIX_BEG
	assign row_calc = {1'b0, vcnt} - 6'(`VID_V_PIX_BEG - 1);
	assign row_vis  = (vcnt >= 5'(`VID_V_PIX_BEG - 1)) && (row_calc < 6'(`VID_V_PIX));

	// zx needs 4 words per line, 4-bit colour needs 8
	assign last_word = (mode_q == video_pkg::MODE_ZX) ? (widx == 3'd3) : (widx == 3'd7);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			row_q  <= '0;
			page_q <= '0;
			widx   <= '0;
			mode_q <= video_pkg::MODE_ZX;
		end else if (line_start) begin
			// a fetch still running here is dropped
			widx   <= '0;
			row_q  <= row_calc[3:0];
			page_q <= scr_page[6:0];
			mode_q <= video_pkg::scr_mode_e'(vconfig[0]);
			state  <= row_vis ? S_REQ : S_IDLE;
		end else begin
			case (state)
				S_REQ: begin
					if (video_next)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (video_strobe) begin
						if (last_word) begin
							state <= S_IDLE;
						end else begin
							widx  <= widx + 3'd1;
							state <= S_REQ;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// address only moves after a strobe, so it is steady while go is high
	assign video_go   = (state == S_REQ);
	assign video_addr = `VID_ADDR_W'({page_q, row_q, widx});

	assign buf_we    = (state == S_WAIT) && video_strobe;
	assign buf_waddr = widx;
	assign buf_wdata = video_data;

endmodule

`default_nettype wire

// ==== design/video_render.sv ====
// video render block with a two-bank line buffer and pixel decode for zx and 4-bit colour modes
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_render (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                line_start,
	input  wire [5:0]          hcnt,
	input  wire                pix_active,
	input  wire [7:0]          vconfig,
	input  wire                buf_we,
	input  wire [2:0]          buf_waddr,
	input  wire [15:0]         buf_wdata,
	output video_pkg::colour_t pix_colour,
	output logic               pix_valid
);

	logic [15:0]          line_buf [2*`VID_LINE_WORDS];
	logic                 wbank;
	video_pkg::scr_mode_e next_mode;
	video_pkg::scr_mode_e mode_q;
	logic [4:0]           pix_x;
	logic [2:0]           ridx;
	video_pkg::vword_u    rword;
	video_pkg::colour_t   colour;
	logic                 ink_sel;

	always_ff @(posedge clk) begin
		if (buf_we)
			line_buf[{wbank, buf_waddr}] <= buf_wdata;
	end

	// mode sampled when the fetch starts and used one line later with its bank
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wbank     <= 1'b0;
			next_mode <= video_pkg::MODE_ZX;
			mode_q    <= video_pkg::MODE_ZX;
		end else if (line_start) begin
			wbank     <= ~wbank;
			next_mode <= video_pkg::scr_mode_e'(vconfig[0]);
			mode_q    <= next_mode;
		end
	end

	assign pix_x = 5'(hcnt - 6'(`VID_H_PIX_BEG));

	// 8 pixels per word in zx, 4 in colour mode
	always_comb begin
		if (mode_q == video_pkg::MODE_ZX)
			ridx = {1'b0, pix_x[4:3]};
		else
			ridx = pix_x[4:2];
	end

	assign rword = line_buf[{~wbank, ridx}];

	always_comb begin
		// bitmap bit 7 is leftmost, set means ink
		ink_sel = rword.zx.bitmap[~pix_x[2:0]];
		if (mode_q == video_pkg::MODE_ZX) begin
			colour.bright = rword.zx.bright;
			if (ink_sel)
				{colour.green, colour.red, colour.blue} = rword.zx.ink;
			else
				{colour.green, colour.red, colour.blue} = rword.zx.paper;
		end else begin
			colour = rword.c4[~pix_x[1:0]];
		end
	end

	always_ff @(posedge clk) begin
		pix_colour <= colour;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pix_valid <= 1'b0;
		else
			pix_valid <= pix_active;
	end

endmodule

`default_nettype wire

// ==== design/video_out.sv ====
// video output stage with border and blanking mux, DAC levels and sync alignment
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_out (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire video_pkg::colour_t pix_colour,
	input  wire                     pix_valid,
	input  wire [5:0]               hcnt,
	input  wire [4:0]               vcnt,
	input  wire                     hsync_raw,
	input  wire                     vsync_raw,
	input  wire [7:0]               border,
	output logic [1:0]              vred,
	output logic [1:0]              vgrn,
	output logic [1:0]              vblu,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    csync
);

	logic               vis_d;
	logic               hs_d;
	logic               vs_d;
	video_pkg::colour_t sel;

	// off 00, on 10, on and bright 11
	function automatic logic [1:0] dac_level(input logic on, input logic bright);
		dac_level = on ? {1'b1, bright} : 2'b00;
	endfunction

	always_comb begin
		sel = '0;
		if (pix_valid) begin
			sel = pix_colour;
		end else if (vis_d) begin
			sel.bright = 1'b0;
			{sel.green, sel.red, sel.blue} = border[2:0];
		end
	end

	// first stage matches the render register, second drives the pins
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vis_d <= 1'b0;
			hs_d  <= 1'b1;
			vs_d  <= 1'b1;
			vred  <= 2'b00;
			vgrn  <= 2'b00;
			vblu  <= 2'b00;
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
		end else begin
			vis_d <= (hcnt < 6'(`VID_H_SYNC_BEG - 4)) && (vcnt < 5'(`VID_V_SYNC_BEG - 1));
			hs_d  <= hsync_raw;
			vs_d  <= vsync_raw;
			vred  <= dac_level(sel.red, sel.bright);
			vgrn  <= dac_level(sel.green, sel.bright);
			vblu  <= dac_level(sel.blue, sel.bright);
			hsync <= hs_d;
			vsync <= vs_d;
			csync <= hs_d & vs_d;
		end
	end

endmodule

`default_nettype wire

// ==== design/video_top.sv ====
// video top level joining the sync, fetch, render and output stages of the zx display
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [7:0]              border,
	input  wire [7:0]              scr_page,
	input  wire [7:0]              vconfig,
	output wire                    video_go,
	output wire [`VID_ADDR_W-1:0]  video_addr,
	input  wire                    video_next,
	input  wire                    video_strobe,
	input  wire [15:0]             video_data,
	output wire [1:0]              vred,
	output wire [1:0]              vgrn,
	output wire [1:0]              vblu,
	output wire                    hsync,
	output wire                    vsync,
	output wire                    csync,
	output wire                    int_start
);

	wire [5:0]               hcnt;
	wire [4:0]               vcnt;
	wire                     line_start;
	wire                     hsync_raw;
	wire                     vsync_raw;
	wire                     pix_active;
	wire                     buf_we;
	wire [2:0]               buf_waddr;
	wire [15:0]              buf_wdata;
	wire video_pkg::colour_t pix_colour;
	wire                     pix_valid;

	video_sync video_sync (
		.clk         (clk        ),
		.rst_n       (rst_n      ),
		.hcnt        (hcnt       ),
		.vcnt        (vcnt       ),
		.line_start  (line_start ),
		.frame_start (           ),
		.int_start   (int_start  ),
		.hsync_raw   (hsync_raw  ),
		.vsync_raw   (vsync_raw  ),
		.pix_active  (pix_active )
	);

	video_fetch video_fetch (
		.clk          (clk         ),
		.rst_n        (rst_n       ),
		.line_start   (line_start  ),
		.vcnt         (vcnt        ),
		.vconfig      (vconfig     ),
		.scr_page     (scr_page    ),
		.video_go     (video_go    ),
		.video_addr   (video_addr  ),
		.video_next   (video_next  ),
		.video_strobe (video_strobe),
		.video_data   (video_data  ),
		.buf_we       (buf_we      ),
		.buf_waddr    (buf_waddr   ),
		.buf_wdata    (buf_wdata   )
	);

	video_render video_render (
		.clk        (clk       ),
		.rst_n      (rst_n     ),
		.line_start (line_start),
		.hcnt       (hcnt      ),
		.pix_active (pix_active),
		.vconfig    (vconfig   ),
		.buf_we     (buf_we    ),
		.buf_waddr  (buf_waddr ),
		.buf_wdata  (buf_wdata ),
		.pix_colour (pix_colour),
		.pix_valid  (pix_valid )
	);

	video_out video_out (
		.clk        (clk       ),
		.rst_n      (rst_n     ),
		.pix_colour (pix_colour),
		.pix_valid  (pix_valid ),
		.hcnt       (hcnt      ),
		.vcnt       (vcnt      ),
		.hsync_raw  (hsync_raw ),
		.vsync_raw  (vsync_raw ),
		.border     (border    ),
		.vred       (vred      ),
		.vgrn       (vgrn      ),
		.vblu       (vblu      ),
		.hsync      (hsync     ),
		.vsync      (vsync     ),
		.csync      (csync     )
	);

endmodule

`default_nettype wire

// ==== dv/video_tb.sv ====
// video testbench running trace-driven sync, DRAM handshake and pixel checks
`timescale 1ns/1ps
`include "video_cfg.svh"
`default_nettype none

module video_tb;

	localparam int LINE  = `VID_H_TOTAL;
	localparam int FRAME = `VID_H_TOTAL * `VID_V_TOTAL;

	logic                   clk;
	logic                   rst_n;
	logic [7:0]             border;
	logic [7:0]             scr_page;
	logic [7:0]             vconfig;
	logic                   video_next;
	logic                   video_strobe;
	logic [15:0]            video_data;
	wire                    video_go;
	wire [`VID_ADDR_W-1:0]  video_addr;
	wire [1:0]              vred;
	wire [1:0]              vgrn;
	wire [1:0]              vblu;
	wire                    hsync;
	wire                    vsync;
	wire                    csync;
	wire                    int_start;

	int                     n;
	int                     check_frame;
	int                     err_cnt;
	int                     chk_cnt;
	logic                   timed_out;
	logic [15:0]            salt;
	int                     ph;
	int                     cnt;
	logic [`VID_ADDR_W-1:0] req_addr;
	logic                   outstanding;
	logic                   go_q;
	logic [`VID_ADDR_W-1:0] addr_q;
	int                     line_reqs;
	int                     n_probes;
	int                     probe_hits;
	int                     pr_row [16];
	int                     pr_col [16];
	logic [5:0]             pr_rgb [16];

	video_top uut (
		.clk          (clk         ),
		.rst_n        (rst_n       ),
		.border       (border      ),
		.scr_page     (scr_page    ),
		.vconfig      (vconfig     ),
		.video_go     (video_go    ),
		.video_addr   (video_addr  ),
		.video_next   (video_next  ),
		.video_strobe (video_strobe),
		.video_data   (video_data  ),
		.vred         (vred        ),
		.vgrn         (vgrn        ),
		.vblu         (vblu        ),
		.hsync        (hsync       ),
		.vsync        (vsync       ),
		.csync        (csync       ),
		.int_start    (int_start   )
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// clocks since reset release; hcnt equals n mod LINE
	always @(posedge clk) begin
		if (rst_n)
			n <= n + 1;
	end

	// fill pattern mixing page and row bits into the upper byte
	function automatic logic [15:0] mem_word(input logic [`VID_ADDR_W-1:0] a);
		logic [7:0] lo;
		lo = a[7:0];
		mem_word = {a[14:7] ^ lo, lo} ^ salt;
	endfunction

	function automatic logic [1:0] level(input logic on, input logic bright);
		if (!on)
			level = 2'b00;
		else if (bright)
			level = 2'b11;
		else
			level = 2'b10;
	endfunction

	// {vred, vgrn, vblu} for raster position (h, v)
	function automatic logic [5:0] expected_rgb(input int h, input int v);
		video_pkg::vword_u  w;
		video_pkg::colour_t c;
		logic [2:0]         grb;
		logic               bright;
		int                 x;
		int                 row;
		expected_rgb = '0;
		x = h - `VID_H_PIX_BEG;
		row = v - `VID_V_PIX_BEG;
		if (x >= 0 && x < `VID_H_PIX && row >= 0 && row < `VID_V_PIX) begin
			if (vconfig[0] == 1'b0) begin
				w = mem_word({1'b0, scr_page[6:0], 4'(row), 3'(x / 8)});
				bright = w.zx.bright;
				grb = w.zx.bitmap[3'(7 - x % 8)] ? w.zx.ink : w.zx.paper;
			end else begin
				w = mem_word({1'b0, scr_page[6:0], 4'(row), 3'(x / 4)});
				c = w.c4[2'(3 - x % 4)];
				bright = c.bright;
				grb = {c.green, c.red, c.blue};
			end
			expected_rgb = {level(grb[1], bright), level(grb[2], bright), level(grb[0], bright)};
		end else if (h < `VID_H_SYNC_BEG - 4 && v < `VID_V_SYNC_BEG - 1) begin
			expected_rgb = {level(border[1], 1'b0), level(border[2], 1'b0),
				level(border[0], 1'b0)};
		end
	endfunction

	task automatic flag_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic compare_outputs();
		int         pos;
		int         h;
		int         v;
		logic       hs;
		logic       vs;
		logic [5:0] exp_rgb;
		pos = n - 2;
		h = pos % LINE;
		v = (pos / LINE) % `VID_V_TOTAL;
		hs = !(h >= `VID_H_SYNC_BEG && h < `VID_H_SYNC_BEG + `VID_H_SYNC_LEN);
		vs = !(v >= `VID_V_SYNC_BEG && v < `VID_V_SYNC_BEG + `VID_V_SYNC_LEN);
		if (hsync !== hs || vsync !== vs || csync !== (hs & vs))
			flag_error($sformatf("syncs %b%b%b at h=%0d v=%0d", hsync, vsync, csync, h, v));
		if (int_start !== (n % FRAME == 0))
			flag_error($sformatf("int_start %b at clock %0d", int_start, n));
		if (pos / FRAME == check_frame) begin
			exp_rgb = expected_rgb(h, v);
			chk_cnt++;
			if ({vred, vgrn, vblu} !== exp_rgb)
				flag_error($sformatf("pixel h=%0d v=%0d got %h expected %h",
					h, v, {vred, vgrn, vblu}, exp_rgb));
			for (int i = 0; i < n_probes; i++) begin
				if (h == pr_col[i] + `VID_H_PIX_BEG && v == pr_row[i] + `VID_V_PIX_BEG) begin
					probe_hits++;
					if ({vred, vgrn, vblu} !== pr_rgb[i])
						flag_error($sformatf("probe row %0d col %0d got %h expected %h",
							pr_row[i], pr_col[i], {vred, vgrn, vblu}, pr_rgb[i]));
				end
			end
		end
	endtask

	task automatic watch_dram();
		int                     v;
		int                     row;
		int                     exp_reqs;
		logic [`VID_ADDR_W-1:0] exp_addr;
		if (video_go && go_q && video_addr != addr_q)
			flag_error("video_addr moved while video_go was high");
		if (video_go && outstanding)
			flag_error("new request issued before the previous strobe");
		if (video_strobe)
			outstanding = 1'b0;
		if (video_next && video_go) begin
			outstanding = 1'b1;
			if (n / FRAME == check_frame) begin
				v = (n / LINE) % `VID_V_TOTAL;
				exp_addr = {1'b0, scr_page[6:0], 4'(v + 1 - `VID_V_PIX_BEG), 3'(line_reqs)};
				if (video_addr != exp_addr)
					flag_error($sformatf("address %h expected %h", video_addr, exp_addr));
			end
			line_reqs++;
		end
		if (n % LINE == 0) begin
			if ((n - 1) / FRAME == check_frame) begin
				v = ((n - 1) / LINE) % `VID_V_TOTAL;
				row = v + 1 - `VID_V_PIX_BEG;
				exp_reqs = (row >= 0 && row < `VID_V_PIX) ? (vconfig[0] ? 8 : 4) : 0;
				if (line_reqs != exp_reqs)
					flag_error($sformatf("line %0d made %0d requests, expected %0d",
						v, line_reqs, exp_reqs));
			end
			line_reqs = 0;
		end
		go_q = video_go;
		addr_q = video_addr;
	endtask

	always @(negedge clk) begin
		if (rst_n && n >= 2) begin
			compare_outputs();
			watch_dram();
		end
	end

	// DRAM model with accept plus return latency of at most 5 cycles
	always @(posedge clk) begin
		#2;
		video_next = 1'b0;
		video_strobe = 1'b0;
		case (ph)
			0: begin
				if (rst_n && video_go) begin
					cnt = 1 + $urandom % 3;
					ph = 1;
				end
			end
			1: begin
				cnt--;
				if (cnt == 0) begin
					video_next = 1'b1;
					req_addr = video_addr;
					cnt = 1 + $urandom % 2;
					ph = 2;
				end
			end
			default: begin
				cnt--;
				if (cnt == 0) begin
					video_strobe = 1'b1;
					video_data = mem_word(req_addr);
					ph = 0;
				end
			end
		endcase
	end

	// settle one frame, then check the whole following frame
	task automatic run_case(input logic [7:0] mode, input logic [7:0] bord,
		input logic [7:0] page, input logic [15:0] slt);
		int clocks;
		@(posedge clk);
		#2;
		vconfig = {7'd0, mode[0]};
		border = bord;
		scr_page = page;
		salt = slt;
		probe_hits = 0;
		check_frame = n / FRAME + 2;
		clocks = 0;
		while (n < (check_frame + 1) * FRAME + 4 && !timed_out) begin
			@(posedge clk);
			clocks++;
			if (clocks > 4 * FRAME) begin
				$display("timeout: raster did not reach the end of the checked frame");
				err_cnt++;
				timed_out = 1'b1;
			end
		end
		if (probe_hits != n_probes)
			flag_error($sformatf("%0d of %0d probes seen", probe_hits, n_probes));
	endtask

	initial begin
		int          fd;
		string       line;
		logic [7:0]  mode;
		logic [7:0]  bord;
		logic [7:0]  page;
		logic [15:0] slt;
		int          r;
		int          g;
		int          b;
		void'($urandom(32'hcfc1));
		rst_n = 1'b0;
		border = '0;
		scr_page = '0;
		vconfig = '0;
		video_next = 1'b0;
		video_strobe = 1'b0;
		video_data = '0;
		salt = '0;
		n = 0;
		check_frame = -1;
		err_cnt = 0;
		chk_cnt = 0;
		timed_out = 1'b0;
		ph = 0;
		cnt = 0;
		outstanding = 1'b0;
		go_q = 1'b0;
		addr_q = '0;
		line_reqs = 0;
		n_probes = 0;
		repeat (10) @(posedge clk);
		#2 rst_n = 1'b1;
		fd = $fopen("dv/video_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file dv/video_trace.txt");
			err_cnt++;
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#" &&
					$sscanf(line, "c %h %h %h %h %d", mode, bord, page, slt, n_probes) == 5) begin
					for (int i = 0; i < n_probes; i++) begin
						if ($fgets(line, fd) == 0 || $sscanf(line, "p %d %d %d %d %d",
							pr_row[i], pr_col[i], r, g, b) != 5) begin
							$display("malformed probe line in the trace file");
							err_cnt++;
						end
						pr_rgb[i] = {2'(r), 2'(g), 2'(b)};
					end
					run_case(mode, bord, page, slt);
				end
			end
			$fclose(fd);
		end
		if (chk_cnt == 0) begin
			$display("no pixels were checked");
			err_cnt++;
		end
		$display("errors: %0d, pixel checks: %0d", err_cnt, chk_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/video_trace.txt ====
# case: c mode border scr_page salt probe_count (hex, count decimal)
# probe: p row col vred vgrn vblu (decimal, row and col inside the screen area)
c 0 05 03 0000 5
p 0 0 2 0 2
p 0 1 0 0 0
p 5 13 0 2 2
p 15 31 0 0 0
p 15 29 3 3 3
c 1 02 12 5a3c 4
p 0 0 0 2 0
p 2 5 0 0 3
p 9 30 2 2 2
p 14 15 3 3 3
c 0 07 7f 00ff 2
p 1 2 3 3 3
p 1 0 3 3 0

// ==== compile.f ====
+incdir+design
design/video_pkg.sv
design/video_sync.sv
design/video_fetch.sv
design/video_render.sv
design/video_out.sv
design/video_top.sv
dv/video_tb.sv

// ==== Makefile ====
# Verilator build and run of the video testbench

LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -f compile.f --top-module video_tb -o Vvideo_tb
	./obj_dir/Vvideo_tb | tee $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	verilator --lint-only --timing -f compile.f --top-module video_tb

clean:
	rm -rf obj_dir $(LOG)
